//--- verilog/rv_config.svh
/*
  core-wide constants for the single-cycle RV32I core
  widths are fixed to RV32I; changing them is not supported by the decoder
  reset pc must stay four-byte aligned
*/
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural register count and index width
`define RV_NREGS 32
`define RV_RADDR_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- verilog/rv_pkg.sv
/*
  shared types for the RV32I core
  only the integer ALU, upper-immediate, jump and branch opcodes are listed
  loads, stores, fence and system opcodes decode as illegal
*/
`default_nettype none

package rv_pkg;

    // major opcodes recognised by the decoder
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // operand a source
    typedef enum logic {
        A_RS1, A_PC
    } a_sel_e;

    // operand b source
    typedef enum logic [1:0] {
        B_RS2, B_IMM, B_FOUR
    } b_sel_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    // next pc forms
    // PC_TARGET is the unconditional pc + imm used by jal
    typedef enum logic [1:0] {
        PC_PLUS4, PC_BRANCH, PC_TARGET, PC_JALR
    } pc_sel_e;

endpackage

`default_nettype wire

//--- verilog/rv_ctrl_if.sv
/*
  decoded control bundle, decode to execute
  all fields are combinational from the current instruction word
*/
`timescale 1ns/10ps
`default_nettype none

interface rv_ctrl_if;

    rv_pkg::alu_op_e alu_op;
    rv_pkg::a_sel_e  a_sel;
    rv_pkg::b_sel_e  b_sel;
    // sign-extended immediate, already in final position
    logic [31:0]     imm;
    logic            is_branch;
    // raw funct3, picks the branch compare
    logic [2:0]      funct3;
    logic            reg_wen;
    rv_pkg::pc_sel_e pc_sel;

    // decoder owns every field
    modport dec (
        output alu_op, a_sel, b_sel, imm, is_branch, funct3, reg_wen, pc_sel
    );

    modport exe (
        input alu_op, a_sel, b_sel, imm, is_branch, funct3, reg_wen, pc_sel
    );

endinterface

`default_nettype wire

//--- verilog/pc_unit.sv
/*
  program counter and next-pc adder
  pc updates every clock, there is no stall input
  jalr targets have bit 0 cleared; bit 1 is not corrected
*/
`timescale 1ns/10ps
`default_nettype none
`include "rv_config.svh"

module pc_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rv_pkg::pc_sel_e    pc_sel,
    input  wire [`RV_XLEN-1:0]      imm,
    input  wire [`RV_XLEN-1:0]      rs1_data,
    input  wire                     taken,
    output logic [`RV_XLEN-1:0]     pc,
    output logic [`RV_XLEN-1:0]     pc_plus4
);

    localparam logic [`RV_XLEN-1:0] FOUR = 4;

    logic [`RV_XLEN-1:0] base;
    logic [`RV_XLEN-1:0] offset;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] pc_next;

    // sequential fetch address, also the link value
    assign pc_plus4 = pc + FOUR;

    // base is rs1 only for jalr
    assign base = (pc_sel == rv_pkg::PC_JALR) ? rs1_data : pc;

    // untaken branch falls back to +4
    assign offset = (pc_sel == rv_pkg::PC_PLUS4 ||
                     (pc_sel == rv_pkg::PC_BRANCH && !taken)) ? FOUR : imm;

    assign sum = base + offset;
    assign pc_next = (pc_sel == rv_pkg::PC_JALR) ? {sum[`RV_XLEN-1:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch address must stay word aligned out of reset
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
/*
  instruction decoder and immediate generator
  anything outside the supported RV32I subset is flagged illegal and
  retires as a no-op; reg_wen is the only place x0 writes are filtered
*/
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  wire         rst,
    input  wire [31:0]  instr,
    rv_ctrl_if.dec      ctrl,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output logic        illegal
);

    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               wen_raw;
    rv_pkg::imm_fmt_e   imm_fmt;

    // alt selects sub / sra
    function automatic rv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register indices sit in fixed fields
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign ctrl.funct3 = funct3;

    always_comb begin
        // defaults describe a no-op
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.a_sel     = rv_pkg::A_RS1;
        ctrl.b_sel     = rv_pkg::B_RS2;
        ctrl.is_branch = 1'b0;
        ctrl.pc_sel    = rv_pkg::PC_PLUS4;
        imm_fmt        = rv_pkg::IMM_I;
        wen_raw        = 1'b0;
        illegal        = 1'b0;

        case (instr[6:0])
            rv_pkg::OP_LUI: begin
                ctrl.alu_op = rv_pkg::ALU_PASS_B;
                ctrl.b_sel  = rv_pkg::B_IMM;
                imm_fmt     = rv_pkg::IMM_U;
                wen_raw     = 1'b1;
            end
            rv_pkg::OP_AUIPC: begin
                ctrl.a_sel = rv_pkg::A_PC;
                ctrl.b_sel = rv_pkg::B_IMM;
                imm_fmt    = rv_pkg::IMM_U;
                wen_raw    = 1'b1;
            end
            // jumps: alu forms pc + 4 as the link value
            rv_pkg::OP_JAL: begin
                ctrl.a_sel  = rv_pkg::A_PC;
                ctrl.b_sel  = rv_pkg::B_FOUR;
                ctrl.pc_sel = rv_pkg::PC_TARGET;
                imm_fmt     = rv_pkg::IMM_J;
                wen_raw     = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                ctrl.a_sel  = rv_pkg::A_PC;
                ctrl.b_sel  = rv_pkg::B_FOUR;
                ctrl.pc_sel = rv_pkg::PC_JALR;
                wen_raw     = 1'b1;
                illegal     = (funct3 != 3'b000);
            end
            rv_pkg::OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.pc_sel    = rv_pkg::PC_BRANCH;
                imm_fmt        = rv_pkg::IMM_B;
                // funct3 010 and 011 are unassigned
                illegal        = (funct3[2:1] == 2'b01);
            end
            rv_pkg::OP_IMM: begin
                ctrl.b_sel  = rv_pkg::B_IMM;
                ctrl.alu_op = alu_op_of(funct3, funct3 == 3'b101 && instr[30]);
                wen_raw     = 1'b1;
                // shift immediates only allow shamt plus the sra bit
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000 && funct7 != 7'b0100000);
                end
            end
            rv_pkg::OP_REG: begin
                ctrl.alu_op = alu_op_of(funct3, instr[30]);
                wen_raw     = 1'b1;
                // bit 30 only valid for sub and sra
                illegal     = !(funct7 == 7'b0000000 ||
                                (funct7 == 7'b0100000 &&
                                 (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // illegal words retire as plain +4 no-ops
        if (illegal) begin
            ctrl.is_branch = 1'b0;
            ctrl.pc_sel    = rv_pkg::PC_PLUS4;
        end

        ctrl.reg_wen = wen_raw && !illegal && (rd_addr != 5'd0) && !rst;
    end

    // immediate in final bit position, sign from instr[31]
    always_comb begin
        case (imm_fmt)
            rv_pkg::IMM_I: ctrl.imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::IMM_S: ctrl.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::IMM_B: ctrl.imm = {{19{instr[31]}}, instr[31], instr[7],
                                       instr[30:25], instr[11:8], 1'b0};
            rv_pkg::IMM_U: ctrl.imm = {instr[31:12], 12'b0};
            rv_pkg::IMM_J: ctrl.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                       instr[20], instr[30:21], 1'b0};
            default:       ctrl.imm = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
/*
  integer register file, two combinational reads and one write
  x0 reads as zero; writes to it are expected to be filtered upstream
  reset clears every entry
*/
`timescale 1ns/10ps
`default_nettype none
`include "rv_config.svh"

module reg_file (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`RV_RADDR_W-1:0]   raddr_a,
    input  wire [`RV_RADDR_W-1:0]   raddr_b,
    output logic [`RV_XLEN-1:0]     rdata_a,
    output logic [`RV_XLEN-1:0]     rdata_b,
    input  wire                     wen,
    input  wire [`RV_RADDR_W-1:0]   waddr,
    input  wire [`RV_XLEN-1:0]      wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // write lands on the next edge, no bypass to the reads
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // decode must never ask for an x0 write
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wen |-> waddr != '0);

endmodule

`default_nettype wire

//--- verilog/alu_exec.sv
/*
  execute stage: operand muxes, ALU and branch compare
  purely combinational
  jumps return pc + 4 as their result
*/
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
    rv_ctrl_if.exe      ctrl,
    input  wire [31:0]  rs1_data,
    input  wire [31:0]  rs2_data,
    input  wire [31:0]  pc,
    input  wire [31:0]  pc_plus4,
    output logic [31:0] result,
    output logic        taken
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_y;
    logic [4:0]  shamt;
    logic        cond;
    logic        link;

    assign op_a = (ctrl.a_sel == rv_pkg::A_PC) ? pc : rs1_data;

    always_comb begin
        case (ctrl.b_sel)
            rv_pkg::B_IMM:  op_b = ctrl.imm;
            rv_pkg::B_FOUR: op_b = 32'd4;
            default:        op_b = rs2_data;
        endcase
    end

    // only the low five bits shift
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_y = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_y = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_y = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_y = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_y = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_y = $signed(op_a) >>> shamt;
            rv_pkg::ALU_OR:     alu_y = op_a | op_b;
            rv_pkg::ALU_AND:    alu_y = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_y = op_b;
            default:            alu_y = 32'b0;
        endcase
    end

    // branch condition, compares always use the raw register values
    always_comb begin
        case (ctrl.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken = ctrl.is_branch && cond;

    // jal and jalr write the link value
    assign link = (ctrl.pc_sel == rv_pkg::PC_TARGET) || (ctrl.pc_sel == rv_pkg::PC_JALR);
    assign result = link ? pc_plus4 : alu_y;

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
/*
  single-cycle RV32I core top
  instr must be the word at pc within the same cycle
  wb_* and illegal are combinational retire strobes for the current word
  no data memory port, loads and stores retire as illegal
*/
`timescale 1ns/10ps
`default_nettype none
`include "rv_config.svh"

module rv_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`RV_XLEN-1:0]      instr,
    output logic [`RV_XLEN-1:0]     pc,
    output logic                    wb_en,
    output logic [`RV_RADDR_W-1:0]  wb_addr,
    output logic [`RV_XLEN-1:0]     wb_data,
    output logic                    illegal
);

    logic [`RV_RADDR_W-1:0] rs1_addr;
    logic [`RV_RADDR_W-1:0] rs2_addr;
    logic [`RV_RADDR_W-1:0] rd_addr;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
    logic [`RV_XLEN-1:0]    result;
    logic [`RV_XLEN-1:0]    pc_plus4;
    logic                   taken;

    rv_ctrl_if ctrl_bus ();

    instr_decode u_decode (
        .rst      (rst),
        .instr    (instr),
        .ctrl     (ctrl_bus),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .illegal  (illegal)
    );

    // write port doubles as the retire interface
    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rs1_addr),
        .raddr_b (rs2_addr),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data),
        .wen     (ctrl_bus.reg_wen),
        .waddr   (rd_addr),
        .wdata   (result)
    );

    alu_exec u_exec (
        .ctrl     (ctrl_bus),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .result   (result),
        .taken    (taken)
    );

    pc_unit u_pc (
        .clk      (clk),
        .rst      (rst),
        .pc_sel   (ctrl_bus.pc_sel),
        .imm      (ctrl_bus.imm),
        .rs1_data (rs1_data),
        .taken    (taken),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    // reg_wen is already low in reset and for x0
    assign wb_en   = ctrl_bus.reg_wen;
    assign wb_addr = rd_addr;
    assign wb_data = result;

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
/*
  testbench for the single-cycle RV32I core
  random program of legal and illegal words, forward jumps only
  instr comes from the model pc, which is checked against the DUT pc
  jalr always uses x0 as base so targets stay inside the program
*/
`timescale 1ns/10ps
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

    localparam int PROG_LEN = 200;
    localparam logic [31:0] LAST_PC = 32'((PROG_LEN - 1) * 4);
    // worst case is one word per cycle plus reset
    localparam int TIMEOUT = 4 * PROG_LEN + 20;

    typedef struct packed {
        logic [31:0] next_pc;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        illegal;
    } step_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] prog [PROG_LEN];
    // architectural model state
    logic [31:0] regs_m [32];
    logic [31:0] pc_m;
    int          cycles;

    rv_core DUT (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .illegal (illegal)
    );

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, want);
            $display("** FAIL **");
            $fatal(1, "DUT output differs from the reference model");
        end
    endtask

    // integer ops as listed in the ISA manual, alt picks sub and sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // one instruction of the architectural model
    function automatic step_t ref_step(input logic [31:0] w, input logic [31:0] pc_v,
                                       input logic [31:0] a, input logic [31:0] b);
        step_t       r;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        ill;
        logic        tk;
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'b0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        r.next_pc = pc_v + 32'd4;
        r.wen = 1'b0;
        r.waddr = w[11:7];
        r.wdata = 32'd0;
        ill = 1'b0;
        tk = 1'b0;
        case (w[6:0])
            7'b0110111: begin
                r.wen = 1'b1;
                r.wdata = imm_u;
            end
            7'b0010111: begin
                r.wen = 1'b1;
                r.wdata = pc_v + imm_u;
            end
            7'b1101111: begin
                r.wen = 1'b1;
                r.wdata = pc_v + 32'd4;
                r.next_pc = pc_v + imm_j;
            end
            7'b1100111: begin
                ill = (f3 != 3'd0);
                r.wen = 1'b1;
                r.wdata = pc_v + 32'd4;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                case (f3)
                    3'd0:    tk = (a == b);
                    3'd1:    tk = (a != b);
                    3'd4:    tk = ($signed(a) < $signed(b));
                    3'd5:    tk = ($signed(a) >= $signed(b));
                    3'd6:    tk = (a < b);
                    3'd7:    tk = (a >= b);
                    default: ill = 1'b1;
                endcase
                if (tk) begin
                    r.next_pc = pc_v + imm_b;
                end
            end
            7'b0010011: begin
                // shift immediates: funct7 is 0, or 0x20 for srai
                if (f3 == 3'd1) begin
                    ill = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    ill = (f7 != 7'h00 && f7 != 7'h20);
                end
                r.wen = 1'b1;
                r.wdata = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
            end
            7'b0110011: begin
                ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                r.wen = 1'b1;
                r.wdata = alu_ref(f3, w[30], a, b);
            end
            default: begin
                ill = 1'b1;
            end
        endcase
        // illegal words are no-ops, x0 is never written
        if (ill) begin
            r.wen = 1'b0;
            r.next_pc = pc_v + 32'd4;
        end
        if (r.waddr == 5'd0) begin
            r.wen = 1'b0;
        end
        r.illegal = ill;
        return r;
    endfunction

    // random word for slot idx, jump targets land ahead within the program
    function automatic logic [31:0] gen_word(input int idx);
        logic [31:0] w;
        logic [31:0] off;
        logic [31:0] tgt;
        logic [4:0]  rd;
        logic [2:0]  f3;
        int          span;
        int          kind;
        w = $urandom;
        // rs1 within x0..x15 to reuse written registers
        w[19] = 1'b0;
        rd = 5'($urandom % 16);
        f3 = w[14:12];
        kind = int'($urandom % 10);
        span = PROG_LEN - 1 - idx;
        if (span > 8) begin
            span = 8;
        end
        off = 32'd4;
        if (span == 0) begin
            kind = 0;
        end else begin
            off = 32'(4 * (1 + ($urandom % span)));
        end
        tgt = 32'(idx * 4) + off;
        case (kind)
            0, 1: begin
                w[6:0] = 7'b0010011;
                w[11:7] = rd;
                if (f3 == 3'd1) begin
                    w[31:25] = 7'h00;
                end else if (f3 == 3'd5) begin
                    w[31:25] = {1'b0, w[30], 5'b0};
                end
            end
            4: begin
                w[6:0] = w[31] ? 7'b0110111 : 7'b0010111;
                w[11:7] = rd;
            end
            5: w = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            // bit 0 of the jalr immediate is random, target drops it
            6: w = {tgt[11:1], w[0], 5'd0, 3'b000, rd, 7'b1100111};
            7: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                w = {off[12], off[10:5], 1'b0, w[23:20], w[19:15], f3,
                     off[4:1], off[11], 7'b1100011};
            end
            8: begin
                case ($urandom % 3)
                    0: w[6:0] = 7'b0000011;
                    1: begin
                        w[31:25] = 7'h01;
                        w[6:0] = 7'b0110011;
                    end
                    default: begin
                        w[14:13] = 2'b01;
                        w[6:0] = 7'b1100011;
                    end
                endcase
            end
            default: begin
                w[6:0] = 7'b0110011;
                w[11:7] = rd;
                w[24] = 1'b0;
                w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'h00;
            end
        endcase
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr = 32'd0;
        cycles = 0;
        pc_m = `RV_RESET_PC;
        void'($urandom(32'h22d));
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = 32'd0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = gen_word(i);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

    // instruction memory and run limit
    always @(posedge clk) begin
        instr <= prog[pc_m[9:2]];
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: last program word not reached after %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        step_t want;
        if (rst) begin
            compare_value("pc", pc, `RV_RESET_PC);
            compare_value("wb_en", 32'(wb_en), 32'd0);
        end else begin
            want = ref_step(instr, pc_m, regs_m[instr[19:15]], regs_m[instr[24:20]]);
            compare_value("pc", pc, pc_m);
            compare_value("illegal", 32'(illegal), 32'(want.illegal));
            compare_value("wb_en", 32'(wb_en), 32'(want.wen));
            if (want.wen) begin
                compare_value("wb_addr", 32'(wb_addr), 32'(want.waddr));
                compare_value("wb_data", wb_data, want.wdata);
                regs_m[want.waddr] = want.wdata;
            end
            if (pc_m == LAST_PC) begin
                $display("** PASS **");
                $finish;
            end else begin
                pc_m = want.next_pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_ctrl_if.sv
verilog/pc_unit.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/rv_core.sv
verification/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rv_core testbench with Verilator and run it
# exit status is nonzero when the testbench stops on an error
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_rv_core \
    -Mdir obj_dir \
    -o sim_tb_rv_core

./obj_dir/sim_tb_rv_core
